//--- source/cu_consts.svh
`ifndef CU_CONSTS_SVH
`define CU_CONSTS_SVH

`default_nettype none

// instruction register
`define CU_IR_WIDTH 32

// instruction class field, bits 27 to 25
`define CU_CLASS_MSB 27
`define CU_CLASS_LSB 25

// set in a branch for branch with link
`define CU_LINK_BIT 20

// control word field widths
`define CU_MC_WIDTH 3
`define CU_T_WIDTH 3

`default_nettype wire

`endif

//--- source/cuPkg.sv
`include "cu_consts.svh"

`default_nettype none

package cuPkg;

	// class field of the instruction, 4, 6 and 7 are undefined
	typedef enum logic [`CU_CLASS_MSB-`CU_CLASS_LSB:0] {
		classDpShift = 3'd0,
		classDpImm   = 3'd1,
		classLsImm   = 3'd2,
		classLsReg   = 3'd3,
		classBranch  = 3'd5
	} instrClassT;

	// numbering kept from the old microcode listing
	typedef enum logic [6:0] {
		stIdle         = 7'd0,
		stFetchAddr    = 7'd1,
		stFetchRead    = 7'd2,
		stFetchWait    = 7'd3,
		stDecode       = 7'd4,
		stDpShift      = 7'd5,
		stDpFlags      = 7'd6,
		stDpImm        = 7'd7,
		stBranchTarget = 7'd8,
		stBranchPc     = 7'd9,
		stBranchLink   = 7'd10
	} cuStateT;

	// alu function codes used by the microcode
	typedef enum logic [4:0] {
		aluAnd     = 5'd0,
		aluAdd     = 5'd4,
		aluPassA   = 5'd16,
		aluAddFour = 5'd17,
		aluPassB   = 5'd19
	} aluOpT;

	typedef struct packed {
		logic                    rfLd;
		logic                    irLd;
		logic                    marLd;
		logic                    frLd;
		logic                    rw;
		logic                    mov;
		logic [1:0]              mA;
		logic [1:0]              mB;
		logic [`CU_MC_WIDTH-1:0] mC;
		logic                    mD;
		logic [1:0]              mF;
		logic                    mH;
		logic                    mI;
		logic [1:0]              mJ;
		logic                    e;
		logic [`CU_T_WIDTH-1:0]  t;
		// shift select S2
		logic                    shiftSel;
		aluOpT                   op;
	} controlWordT;

endpackage

`default_nettype wire

//--- source/instrDecoder.sv
`include "cu_consts.svh"

`default_nettype none

module instrDecoder (
	input  logic [`CU_IR_WIDTH-1:0] ir,
	output cuPkg::cuStateT          entryState
);

	import cuPkg::*;

	instrClassT instrClass;
	logic       link;

	assign instrClass = instrClassT'(ir[`CU_CLASS_MSB:`CU_CLASS_LSB]);
	assign link = ir[`CU_LINK_BIT];

	// first execute state, the sequencer decides whether it is taken
	always_comb
	begin
		case (instrClass)
			classDpShift:
				entryState = stDpShift;
			classDpImm:
				entryState = stDpImm;
			classBranch:
			begin
				if (link)
					entryState = stBranchLink;
				else
					entryState = stBranchTarget;
			end
			// load/store and undefined classes go back to fetch
			default:
				entryState = stFetchAddr;
		endcase
	end

endmodule

`default_nettype wire

//--- source/cuSequencer.sv
`default_nettype none

module cuSequencer (
	input  logic           CLK,
	input  logic           CLR,
	input  logic           cond,
	input  logic           moc,
	input  cuPkg::cuStateT entryState,
	output cuPkg::cuStateT state
);

	import cuPkg::*;

	cuStateT nextState;

	always_ff @(posedge CLK or negedge CLR)
	begin
		if (!CLR)
			state <= stIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = stFetchAddr;
		case (state)
			stIdle:
				nextState = stFetchAddr;
			stFetchAddr:
				nextState = stFetchRead;
			stFetchRead:
				nextState = stFetchWait;
			// hold until memory reports completion
			stFetchWait:
			begin
				if (moc)
					nextState = stDecode;
				else
					nextState = stFetchWait;
			end
			// condition false skips the instruction
			stDecode:
			begin
				if (cond)
					nextState = entryState;
				else
					nextState = stFetchAddr;
			end
			stDpShift:
				nextState = stDpFlags;
			stDpFlags:
				nextState = stFetchAddr;
			stDpImm:
				nextState = stFetchAddr;
			// link step saves the return address first
			stBranchLink:
				nextState = stBranchTarget;
			stBranchTarget:
				nextState = stBranchPc;
			stBranchPc:
				nextState = stFetchAddr;
			default:
				nextState = stFetchAddr;
		endcase
	end

endmodule

`default_nettype wire

//--- source/controlStore.sv
`include "cu_consts.svh"

`default_nettype none

module controlStore (
	input  cuPkg::cuStateT     state,
	output cuPkg::controlWordT ctrl
);

	import cuPkg::*;

	// microcode table, fields not set stay zero
	always_comb
	begin
		ctrl = '0;
		case (state)
			// MAR <= PC
			stFetchAddr:
			begin
				ctrl.marLd = 1'b1;
				ctrl.mA = 2'd2;
				ctrl.mD = 1'b1;
				ctrl.op = aluPassA;
			end
			// start memory read, PC <= PC + 4
			stFetchRead:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
				ctrl.mA = 2'd2;
				ctrl.mC = `CU_MC_WIDTH'(1);
				ctrl.mD = 1'b1;
				ctrl.op = aluAddFour;
			end
			stFetchWait:
			begin
				ctrl.irLd = 1'b1;
				ctrl.rw = 1'b1;
				ctrl.mov = 1'b1;
			end
			stDpShift:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.mB = 2'd1;
				ctrl.mC = `CU_MC_WIDTH'(4);
				ctrl.mD = 1'b1;
				ctrl.t = `CU_T_WIDTH'(1);
				ctrl.e = 1'b1;
				ctrl.op = aluPassB;
			end
			stDpFlags:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mJ = 2'd1;
			end
			stDpImm:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mB = 2'd1;
				ctrl.mH = 1'b1;
				ctrl.mI = 1'b1;
			end
			// shifted offset into the temp register
			stBranchTarget:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.frLd = 1'b1;
				ctrl.mB = 2'd1;
				ctrl.mC = `CU_MC_WIDTH'(4);
				ctrl.mD = 1'b1;
				ctrl.mF = 2'd3;
				ctrl.mJ = 2'd3;
				ctrl.e = 1'b1;
				ctrl.t = `CU_T_WIDTH'(4);
				ctrl.op = aluPassB;
			end
			stBranchPc:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.mA = 2'd2;
				ctrl.mC = `CU_MC_WIDTH'(3);
				ctrl.mD = 1'b1;
				ctrl.mJ = 2'd1;
				ctrl.shiftSel = 1'b1;
				ctrl.op = aluAdd;
			end
			// return address into the link register
			stBranchLink:
			begin
				ctrl.rfLd = 1'b1;
				ctrl.mA = 2'd3;
				ctrl.mC = `CU_MC_WIDTH'(4);
				ctrl.mD = 1'b1;
				ctrl.mJ = 2'd1;
				ctrl.shiftSel = 1'b1;
				ctrl.op = aluAdd;
			end
			// idle and decode drive nothing
			default:
				ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/controlUnit.sv
`include "cu_consts.svh"

`default_nettype none

module controlUnit (
	input  logic                    CLK,
	input  logic                    CLR,
	input  logic                    cond,
	input  logic                    moc,
	input  logic [`CU_IR_WIDTH-1:0] ir,
	output logic                    rfLd,
	output logic                    irLd,
	output logic                    marLd,
	output logic                    frLd,
	output logic                    rw,
	output logic                    mov,
	output logic [1:0]              mA,
	output logic [1:0]              mB,
	output logic [`CU_MC_WIDTH-1:0] mC,
	output logic                    mD,
	output logic [1:0]              mF,
	output logic                    mH,
	output logic                    mI,
	output logic [1:0]              mJ,
	output logic                    e,
	output logic [`CU_T_WIDTH-1:0]  t,
	output logic                    shiftSel,
	output logic [4:0]              op
);

	cuPkg::cuStateT     entryState;
	cuPkg::cuStateT     state;
	cuPkg::controlWordT ctrl;

	instrDecoder i_instrDecoder (
		.ir         (ir),
		.entryState (entryState)
	);

	cuSequencer i_cuSequencer (
		.CLK        (CLK),
		.CLR        (CLR),
		.cond       (cond),
		.moc        (moc),
		.entryState (entryState),
		.state      (state)
	);

	controlStore i_controlStore (
		.state (state),
		.ctrl  (ctrl)
	);

	// control word out to the datapath
	assign rfLd = ctrl.rfLd;
	assign irLd = ctrl.irLd;
	assign marLd = ctrl.marLd;
	assign frLd = ctrl.frLd;
	assign rw = ctrl.rw;
	assign mov = ctrl.mov;
	assign mA = ctrl.mA;
	assign mB = ctrl.mB;
	assign mC = ctrl.mC;
	assign mD = ctrl.mD;
	assign mF = ctrl.mF;
	assign mH = ctrl.mH;
	assign mI = ctrl.mI;
	assign mJ = ctrl.mJ;
	assign e = ctrl.e;
	assign t = ctrl.t;
	assign shiftSel = ctrl.shiftSel;
	assign op = ctrl.op;

endmodule

`default_nettype wire

//--- sim/cuProperties.sv
`default_nettype none

module cuProperties (
	input logic       CLK,
	input logic       CLR,
	input logic       moc,
	input logic       rfLd,
	input logic       irLd,
	input logic       marLd,
	input logic       frLd,
	input logic       rw,
	input logic       mov,
	input logic [1:0] mA,
	input logic [1:0] mB,
	input logic [2:0] mC,
	input logic       mD,
	input logic [1:0] mF,
	input logic       mH,
	input logic       mI,
	input logic [1:0] mJ,
	input logic       e,
	input logic [2:0] t,
	input logic       shiftSel,
	input logic [4:0] op
);

	timeunit 1ns;
	timeprecision 1ps;

	logic anyOn;

	assign anyOn = |{rfLd, irLd, marLd, frLd, rw, mov, mA, mB, mC, mD, mF, mH, mI, mJ,
		e, t, shiftSel, op};

	// instruction load happens only during a memory read
	irLdRead: assert property (@(posedge CLK) disable iff (!CLR) irLd |-> (rw && mov))
		else $error("irLd without rw and mov");

	// decode word follows the end of the memory wait
	decodeZero: assert property (@(posedge CLK) disable iff (!CLR) (irLd && moc) |=> !anyOn)
		else $error("control word not zero after fetch wait");

	marRfExclusive: assert property (@(posedge CLK) disable iff (!CLR) !(marLd && rfLd))
		else $error("marLd and rfLd both high");

	shiftWrites: assert property (@(posedge CLK) disable iff (!CLR) e |-> rfLd)
		else $error("shifter enabled without register load");

endmodule

bind controlUnit cuProperties i_cuProperties (.*);

`default_nettype wire

//--- sim/controlUnitTb.sv
`default_nettype none

module controlUnitTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numTests = 40;
	localparam int cycleLimit = 16 + numTests * (7 + 7) + 50;

	typedef enum int {
		sIdle, sFetchAddr, sFetchRead, sFetchWait, sDecode, sDpShift, sDpFlags,
		sDpImm, sBranchTarget, sBranchPc, sBranchLink
	} stepT;

	typedef stepT stepListT[$];

	typedef struct packed {
		logic       rfLd;
		logic       irLd;
		logic       marLd;
		logic       frLd;
		logic       rw;
		logic       mov;
		logic [1:0] mA;
		logic [1:0] mB;
		logic [2:0] mC;
		logic       mD;
		logic [1:0] mF;
		logic       mH;
		logic       mI;
		logic [1:0] mJ;
		logic       e;
		logic [2:0] t;
		logic       shiftSel;
		logic [4:0] op;
	} wordT;

	logic        CLK;
	logic        CLR;
	logic        cond;
	logic        moc;
	logic [31:0] ir;
	logic        rfLd, irLd, marLd, frLd, rw, mov, mD, mH, mI, e, shiftSel;
	logic [1:0]  mA, mB, mF, mJ;
	logic [2:0]  mC, t;
	logic [4:0]  op;

	stepT expSteps[$];
	bit   expLast[$];
	int   errors = 0;
	int   testErrors = 0;
	int   passCount = 0;
	int   failCount = 0;
	int   doneTests = 0;
	int   cycles = 0;

	controlUnit i_controlUnit (.*);

	initial
		CLK = 1'b0;

	always
		#5 CLK = ~CLK;

	// microcode word expected for each step
	function automatic wordT expectedWord(input stepT s);
		wordT w;
		w = '0;
		case (s)
			sFetchAddr:
				w = '{marLd: 1, mA: 2, mD: 1, op: 16, default: 0};
			sFetchRead:
				w = '{rfLd: 1, rw: 1, mov: 1, mA: 2, mC: 1, mD: 1, op: 17, default: 0};
			sFetchWait:
				w = '{irLd: 1, rw: 1, mov: 1, default: 0};
			sDpShift:
				w = '{rfLd: 1, mB: 1, mC: 4, mD: 1, t: 1, e: 1, op: 19, default: 0};
			sDpFlags:
				w = '{rfLd: 1, frLd: 1, mJ: 1, default: 0};
			sDpImm:
				w = '{rfLd: 1, frLd: 1, mB: 1, mH: 1, mI: 1, default: 0};
			sBranchTarget:
				w = '{rfLd: 1, frLd: 1, mB: 1, mC: 4, mD: 1, mF: 3, mJ: 3, e: 1, t: 4,
					op: 19, default: 0};
			sBranchPc:
				w = '{rfLd: 1, mA: 2, mC: 3, mD: 1, mJ: 1, shiftSel: 1, op: 4, default: 0};
			sBranchLink:
				w = '{rfLd: 1, mA: 3, mC: 4, mD: 1, mJ: 1, shiftSel: 1, op: 4, default: 0};
			default:
				w = '0;
		endcase
		return w;
	endfunction

	// path through the machine for one instruction
	function automatic stepListT stepsFor(input logic [31:0] word, input logic c);
		stepListT s;
		s = '{sFetchAddr, sFetchRead, sFetchWait, sDecode};
		if (c)
		begin
			case (word[27:25])
				3'd0:
				begin
					s.push_back(sDpShift);
					s.push_back(sDpFlags);
				end
				3'd1:
					s.push_back(sDpImm);
				3'd5:
				begin
					if (word[20])
						s.push_back(sBranchLink);
					s.push_back(sBranchTarget);
					s.push_back(sBranchPc);
				end
				default:
					;
			endcase
		end
		return s;
	endfunction

	function automatic logic [2:0] directedClass(input int i);
		case (i)
			0: return 3'd0;
			1: return 3'd1;
			2: return 3'd5;
			3: return 3'd5;
			4: return 3'd2;
			5: return 3'd3;
			6: return 3'd6;
			default: return 3'd0;
		endcase
	endfunction

	task automatic queueSteps(input stepListT s);
		for (int k = 0; k < s.size(); k++)
		begin
			expSteps.push_back(s[k]);
			expLast.push_back(k == s.size() - 1);
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		$display("FAIL %s expected %h got %h at %0t", name, expVal, actVal, $time);
		errors++;
		testErrors++;
	endtask

	task automatic compareOutputs(input wordT w);
		if (rfLd !== w.rfLd)
			reportMismatch("rfLd", 32'(w.rfLd), 32'(rfLd));
		if (irLd !== w.irLd)
			reportMismatch("irLd", 32'(w.irLd), 32'(irLd));
		if (marLd !== w.marLd)
			reportMismatch("marLd", 32'(w.marLd), 32'(marLd));
		if (frLd !== w.frLd)
			reportMismatch("frLd", 32'(w.frLd), 32'(frLd));
		if (rw !== w.rw)
			reportMismatch("rw", 32'(w.rw), 32'(rw));
		if (mov !== w.mov)
			reportMismatch("mov", 32'(w.mov), 32'(mov));
		if (mA !== w.mA)
			reportMismatch("mA", 32'(w.mA), 32'(mA));
		if (mB !== w.mB)
			reportMismatch("mB", 32'(w.mB), 32'(mB));
		if (mC !== w.mC)
			reportMismatch("mC", 32'(w.mC), 32'(mC));
		if (mD !== w.mD)
			reportMismatch("mD", 32'(w.mD), 32'(mD));
		if (mF !== w.mF)
			reportMismatch("mF", 32'(w.mF), 32'(mF));
		if (mH !== w.mH)
			reportMismatch("mH", 32'(w.mH), 32'(mH));
		if (mI !== w.mI)
			reportMismatch("mI", 32'(w.mI), 32'(mI));
		if (mJ !== w.mJ)
			reportMismatch("mJ", 32'(w.mJ), 32'(mJ));
		if (e !== w.e)
			reportMismatch("e", 32'(w.e), 32'(e));
		if (t !== w.t)
			reportMismatch("t", 32'(w.t), 32'(t));
		if (shiftSel !== w.shiftSel)
			reportMismatch("shiftSel", 32'(w.shiftSel), 32'(shiftSel));
		if (op !== w.op)
			reportMismatch("op", 32'(w.op), 32'(op));
	endtask

	task automatic closeTest();
		if (testErrors == 0)
			passCount++;
		else
			failCount++;
		$display("test %0d done, %0d mismatches", doneTests, testErrors);
		doneTests++;
		testErrors = 0;
	endtask

	// outputs are checked at the rising edge, before the state moves on
	always @(posedge CLK)
	begin
		stepT cur;
		if (!CLR)
			compareOutputs(expectedWord(sIdle));
		else if (expSteps.size() == 0)
		begin
			$display("machine ran a cycle with no step expected at %0t", $time);
			errors++;
		end
		else
		begin
			cur = expSteps[0];
			compareOutputs(expectedWord(cur));
			// fetch wait holds until memory answers
			if (cur != sFetchWait || moc)
			begin
				void'(expSteps.pop_front());
				if (expLast.pop_front())
					closeTest();
			end
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles > cycleLimit)
		begin
			$display("timeout, run did not finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic waitFetchAddr();
		while (marLd !== 1'b1)
			@(negedge CLK);
	endtask

	task automatic waitIrLd();
		while (irLd !== 1'b1)
			@(negedge CLK);
	endtask

	initial
	begin
		logic [31:0] word;
		logic        c;
		int          delay;
		void'($urandom(32'h2933_cea1));
		CLR = 1'b0;
		cond = 1'b0;
		moc = 1'b0;
		ir = '0;
		repeat (16) @(negedge CLK);
		// first cycle after release is still idle
		expSteps.push_back(sIdle);
		expLast.push_back(1'b0);
		CLR = 1'b1;
		for (int i = 0; i < numTests; i++)
		begin
			waitFetchAddr();
			word = $urandom;
			if (i < 8)
			begin
				word[27:25] = directedClass(i);
				word[20] = (i == 3);
				c = (i != 7);
			end
			else
				c = ($urandom % 4) != 0;
			ir = word;
			cond = c;
			queueSteps(stepsFor(word, c));
			delay = $urandom % 8;
			waitIrLd();
			repeat (delay) @(negedge CLK);
			moc = 1'b1;
			@(negedge CLK);
			moc = 1'b0;
		end
		waitFetchAddr();
		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (errors == 0 && expSteps.size() == 0 && doneTests == numTests)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- controlUnit.f
+incdir+source
source/cuPkg.sv
source/instrDecoder.sv
source/cuSequencer.sv
source/controlStore.sv
source/controlUnit.sv
sim/cuProperties.sv
sim/controlUnitTb.sv

//--- Makefile
TOP = controlUnitTb

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f controlUnit.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
